/* verilog/filter_cond_pkg.sv */
/*
 * Shared widths, vector typedefs and packed structs of the filter engine
 * Condition operator and control state enums, FIFO sizing localparams
 */
`default_nettype none

package filter_cond_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 16;
    localparam int SRC_W   = 4;
    localparam int COUNT_W = 16;

    // --------------------------------------------------
    // FIFO and pipeline sizing
    // --------------------------------------------------
    localparam int FIFO_DEPTH    = 16;
    localparam int KERNEL_STAGES = 2;

    // Leaves room for every packet still inside the kernel
    localparam int ALMOST_FULL_LEVEL = FIFO_DEPTH - KERNEL_STAGES;

    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // --------------------------------------------------
    // Vector types
    // --------------------------------------------------
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [SRC_W-1:0]      src_t;
    typedef logic [COUNT_W-1:0]    count_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    // Memory packet, address and source id ride along with the data
    typedef struct packed {
        addr_t addr;
        src_t  src;
        data_t data;
    } packet_t;

    // Unsigned compare operators
    typedef enum logic [2:0] {
        EQ = 3'd0,
        NE = 3'd1,
        LT = 3'd2,
        GT = 3'd3,
        LE = 3'd4,
        GE = 3'd5
    } cond_op_t;

    // One job worth of filter configuration
    typedef struct packed {
        cond_op_t op;
        data_t    mask;
        data_t    operand;
        count_t   count;
    } cond_cfg_t;

    // Job control FSM
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        WAIT_CFG = 3'd1,
        RUN      = 3'd2,
        DRAIN    = 3'd3,
        DONE     = 3'd4
    } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/packet_fifo.sv */
/*
 * Synchronous packet FIFO, circular buffer with occupancy count
 * Write side valid/ready, read side head view with pop, almost-full flag
 */
`timescale 1ns/1ps
`default_nettype none

module packet_fifo (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  filter_cond_pkg::packet_t wr_pkt,
    input  logic                     wr_valid,
    output logic                     wr_ready,
    output filter_cond_pkg::packet_t rd_pkt,
    output logic                     rd_valid,
    input  logic                     rd_pop,
    output logic                     almost_full
);

    // --------------------------------------------------
    // Storage and pointers
    // --------------------------------------------------
    filter_cond_pkg::packet_t   mem [filter_cond_pkg::FIFO_DEPTH];
    filter_cond_pkg::fifo_ptr_t wr_ptr;
    filter_cond_pkg::fifo_ptr_t rd_ptr;
    filter_cond_pkg::fifo_cnt_t count;

    logic do_push;
    logic do_pop;

    assign do_push = wr_valid & wr_ready;
    assign do_pop  = rd_pop & rd_valid;

    // --------------------------------------------------
    // Status flags
    // --------------------------------------------------
    assign wr_ready    = count != filter_cond_pkg::fifo_cnt_t'(filter_cond_pkg::FIFO_DEPTH);
    assign rd_valid    = count != '0;
    assign almost_full =
        count >= filter_cond_pkg::fifo_cnt_t'(filter_cond_pkg::ALMOST_FULL_LEVEL);

    // Head of queue, visible without a read strobe
    assign rd_pkt = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_pkt;
        end
    end

    // --------------------------------------------------
    // Pointer and occupancy update
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == filter_cond_pkg::fifo_ptr_t'(filter_cond_pkg::FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end

            if (do_pop) begin
                if (rd_ptr == filter_cond_pkg::fifo_ptr_t'(filter_cond_pkg::FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end

            // Push and pop together leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/filter_cond_control.sv */
/*
 * Job control FSM of the filter engine
 * Latches the configuration, counts pops, issues pop and done
 */
`timescale 1ns/1ps
`default_nettype none

module filter_cond_control (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  logic                       start,
    input  filter_cond_pkg::cond_cfg_t cfg,
    input  logic                       cfg_valid,
    output logic                       cfg_ready,
    input  logic                       head_valid,
    input  logic                       out_almost_full,
    input  logic                       pipe_empty,
    output logic                       pop,
    output filter_cond_pkg::cond_cfg_t active_cfg,
    output logic                       busy,
    output logic                       done
);

    // --------------------------------------------------
    // State and counters
    // --------------------------------------------------
    filter_cond_pkg::ctrl_state_t state;
    filter_cond_pkg::ctrl_state_t state_next;
    filter_cond_pkg::count_t      remaining;
    filter_cond_pkg::count_t      remaining_next;
    logic                         cfg_fire;

    assign cfg_fire = cfg_valid & cfg_ready;

    // Single point where the pop conditions meet
    assign pop = (state == filter_cond_pkg::RUN) &&
                 (remaining != '0) &&
                 head_valid &&
                 !out_almost_full;

    assign remaining_next = pop ? remaining - 1'b1 : remaining;

    // Status decode straight from the state register
    assign cfg_ready = state == filter_cond_pkg::WAIT_CFG;
    assign busy      = state != filter_cond_pkg::IDLE;
    assign done      = state == filter_cond_pkg::DONE;

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            filter_cond_pkg::IDLE: begin
                if (start) begin
                    state_next = filter_cond_pkg::WAIT_CFG;
                end
            end
            filter_cond_pkg::WAIT_CFG: begin
                if (cfg_fire) begin
                    // Empty job skips straight to the drain check
                    if (cfg.count == '0) begin
                        state_next = filter_cond_pkg::DRAIN;
                    end else begin
                        state_next = filter_cond_pkg::RUN;
                    end
                end
            end
            filter_cond_pkg::RUN: begin
                if (remaining_next == '0) begin
                    state_next = filter_cond_pkg::DRAIN;
                end
            end
            filter_cond_pkg::DRAIN: begin
                if (pipe_empty) begin
                    state_next = filter_cond_pkg::DONE;
                end
            end
            filter_cond_pkg::DONE: begin
                state_next = filter_cond_pkg::IDLE;
            end
            default: begin
                state_next = filter_cond_pkg::IDLE;
            end
        endcase
    end

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state     <= filter_cond_pkg::IDLE;
            remaining <= '0;
        end else begin
            state <= state_next;
            if (cfg_fire) begin
                remaining <= cfg.count;
            end else begin
                remaining <= remaining_next;
            end
        end
    end

    // Held for the whole job
    always_ff @(posedge ap_clk) begin
        if (cfg_fire) begin
            active_cfg <= cfg;
        end
    end

endmodule

`default_nettype wire

/* verilog/filter_cond_kernel.sv */
/*
 * Two-stage masked compare pipeline
 * Marks passing packets and reports when nothing is in flight
 */
`timescale 1ns/1ps
`default_nettype none

module filter_cond_kernel (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  filter_cond_pkg::packet_t   in_pkt,
    input  logic                       in_valid,
    input  filter_cond_pkg::cond_cfg_t cfg,
    output filter_cond_pkg::packet_t   pass_pkt,
    output logic                       pass_valid,
    output logic                       pipe_empty
);

    // --------------------------------------------------
    // Pipeline registers
    // --------------------------------------------------
    logic                     s1_valid;
    filter_cond_pkg::packet_t s1_pkt;
    filter_cond_pkg::data_t   s1_masked;

    logic                     s2_valid;
    logic                     s2_pass;
    filter_cond_pkg::packet_t s2_pkt;

    filter_cond_pkg::data_t   operand_masked;
    logic                     cond_met;

    assign operand_masked = cfg.operand & cfg.mask;

    // Operator evaluation, all compares unsigned
    always_comb begin
        case (cfg.op)
            filter_cond_pkg::EQ: cond_met = s1_masked == operand_masked;
            filter_cond_pkg::NE: cond_met = s1_masked != operand_masked;
            filter_cond_pkg::LT: cond_met = s1_masked <  operand_masked;
            filter_cond_pkg::GT: cond_met = s1_masked >  operand_masked;
            filter_cond_pkg::LE: cond_met = s1_masked <= operand_masked;
            filter_cond_pkg::GE: cond_met = s1_masked >= operand_masked;
            default:             cond_met = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // Valid bits
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
        end
    end

    // Payload moves every cycle, qualified by the valid bits
    always_ff @(posedge ap_clk) begin
        s1_pkt    <= in_pkt;
        s1_masked <= in_pkt.data & cfg.mask;
        s2_pkt    <= s1_pkt;
        s2_pass   <= cond_met;
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    assign pass_pkt   = s2_pkt;
    assign pass_valid = s2_valid & s2_pass;

    // Stage 2 counts as occupied even when its packet fails
    assign pipe_empty = !s1_valid && !s2_valid;

endmodule

`default_nettype wire

/* verilog/filter_cond_engine.sv */
/*
 * Filter-condition engine top level
 * Input FIFO, job control, compare kernel and output FIFO
 */
`timescale 1ns/1ps
`default_nettype none

module filter_cond_engine (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  logic                       start,
    input  filter_cond_pkg::cond_cfg_t cfg,
    input  logic                       cfg_valid,
    output logic                       cfg_ready,
    input  filter_cond_pkg::packet_t   in_pkt,
    input  logic                       in_valid,
    output logic                       in_ready,
    output filter_cond_pkg::packet_t   out_pkt,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic                       busy,
    output logic                       done
);

    // --------------------------------------------------
    // Internal nets
    // --------------------------------------------------
    filter_cond_pkg::packet_t   head_pkt;
    logic                       head_valid;
    logic                       pop;
    filter_cond_pkg::cond_cfg_t active_cfg;
    filter_cond_pkg::packet_t   pass_pkt;
    logic                       pass_valid;
    logic                       pipe_empty;
    logic                       out_almost_full;
    logic                       out_pop;

    assign out_pop = out_valid & out_ready;

    // --------------------------------------------------
    // Input side
    // --------------------------------------------------
    // Packets collect here whether or not a job runs
    packet_fifo in_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_pkt           (in_pkt),
        .wr_valid         (in_valid),
        .wr_ready         (in_ready),
        .rd_pkt           (head_pkt),
        .rd_valid         (head_valid),
        .rd_pop           (pop),
        .almost_full      ()
    );

    // --------------------------------------------------
    // Processing
    // --------------------------------------------------
    filter_cond_control control0 (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .cfg              (cfg),
        .cfg_valid        (cfg_valid),
        .cfg_ready        (cfg_ready),
        .head_valid       (head_valid),
        .out_almost_full  (out_almost_full),
        .pipe_empty       (pipe_empty),
        .pop              (pop),
        .active_cfg       (active_cfg),
        .busy             (busy),
        .done             (done)
    );

    filter_cond_kernel kernel0 (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .in_pkt           (head_pkt),
        .in_valid         (pop),
        .cfg              (active_cfg),
        .pass_pkt         (pass_pkt),
        .pass_valid       (pass_valid),
        .pipe_empty       (pipe_empty)
    );

    // --------------------------------------------------
    // Output side
    // --------------------------------------------------
    // Almost-full reserve covers the kernel stages, so writes never stall
    packet_fifo out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_pkt           (pass_pkt),
        .wr_valid         (pass_valid),
        .wr_ready         (),
        .rd_pkt           (out_pkt),
        .rd_valid         (out_valid),
        .rd_pop           (out_pop),
        .almost_full      (out_almost_full)
    );

endmodule

`default_nettype wire

/* testbench/filter_cond_engine_tb.sv */
/*
 * Testbench for the filter-condition engine
 * Seeded random jobs and packets, queue-based reference model, output monitor
 */
`timescale 1ns/1ps
`default_nettype none

module filter_cond_engine_tb;

    localparam int NUM_JOBS = 24;
    localparam int BP_JOB   = 20;

    logic                       ap_clk;
    logic                       areset_generator;
    logic                       start;
    filter_cond_pkg::cond_cfg_t cfg;
    logic                       cfg_valid;
    logic                       cfg_ready;
    filter_cond_pkg::packet_t   in_pkt;
    filter_cond_pkg::packet_t   out_pkt;
    logic                       in_valid;
    logic                       in_ready;
    logic                       out_valid;
    logic                       out_ready;
    logic                       busy;
    logic                       done;

    filter_cond_pkg::packet_t model_fifo[$];
    filter_cond_pkg::packet_t exp_q[$];
    filter_cond_pkg::packet_t send_q[$];
    int job_new[NUM_JOBS];
    int job_count[NUM_JOBS];
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;
    int value_errors = 0;
    int other_errors = 0;
    int n_checks = 0;
    int done_count = 0;
    int stall_left = 0;
    logic bp_phase = 1'b0;
    logic bp_stalled = 1'b0;
    logic saw_in_full = 1'b0;

    filter_cond_engine dut0 (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .cfg              (cfg),
        .cfg_valid        (cfg_valid),
        .cfg_ready        (cfg_ready),
        .in_pkt           (in_pkt),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .out_pkt          (out_pkt),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .busy             (busy),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // --------------------------------------------------
    // Compare tasks and the filter rule
    // --------------------------------------------------
    task automatic check_pkt(input string name, input filter_cond_pkg::packet_t got,
                             input filter_cond_pkg::packet_t exp);
        n_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Unsigned compare of masked data against masked operand
    function automatic logic cond_holds(input filter_cond_pkg::cond_op_t op,
                                        input filter_cond_pkg::data_t a,
                                        input filter_cond_pkg::data_t b);
        case (op)
            filter_cond_pkg::EQ: return a == b;
            filter_cond_pkg::NE: return a != b;
            filter_cond_pkg::LT: return a < b;
            filter_cond_pkg::GT: return a > b;
            filter_cond_pkg::LE: return a <= b;
            filter_cond_pkg::GE: return a >= b;
            default:             return 1'b0;
        endcase
    endfunction

    // --------------------------------------------------
    // Stimulus tasks
    // --------------------------------------------------
    task automatic send_packets();
        while (send_q.size() != 0) begin
            in_pkt   = send_q.pop_front();
            in_valid = 1'b1;
            // in_ready only moves on the rising edge
            while (!in_ready) @(negedge ap_clk);
            @(negedge ap_clk);
            in_valid = 1'b0;
            // Occasional gap between packets
            if ($urandom % 4 == 0) begin
                @(negedge ap_clk);
            end
        end
    endtask

    task automatic run_job(input filter_cond_pkg::cond_cfg_t c);
        @(negedge ap_clk);
        check_bit("cfg_ready", cfg_ready, 1'b0);
        check_bit("busy", busy, 1'b0);
        start = 1'b1;
        @(negedge ap_clk);
        start = 1'b0;
        check_bit("cfg_ready", cfg_ready, 1'b1);
        check_bit("busy", busy, 1'b1);
        cfg       = c;
        cfg_valid = 1'b1;
        while (!cfg_ready) @(negedge ap_clk);
        @(negedge ap_clk);
        cfg_valid = 1'b0;
        while (!done) @(negedge ap_clk);
        // Done lasts one cycle and the engine returns to idle
        @(negedge ap_clk);
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
    endtask

    // --------------------------------------------------
    // Random output back-pressure with long stalls
    // --------------------------------------------------
    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge ap_clk);
            if (bp_phase && !bp_stalled) begin
                stall_left = 90;
                bp_stalled = 1'b1;
            end else if (stall_left == 0 && $urandom % 50 == 0) begin
                stall_left = 20 + $urandom % 31;
            end
            if (stall_left != 0) begin
                out_ready = 1'b0;
                stall_left--;
            end else begin
                out_ready = ($urandom % 4) != 0;
            end
            // An offered packet leaves on the next rising edge
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("Output packet 0x%h appeared with none expected", out_pkt);
                end else begin
                    check_pkt("out_pkt", out_pkt, exp_q.pop_front());
                end
            end
        end
    end

    // Input full flag, done pulses and the cycle limit
    always @(negedge ap_clk) begin
        cycle_count++;
        if (!in_ready) begin
            saw_in_full = 1'b1;
        end
        if (done) begin
            done_count++;
        end
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, %0d packets still expected",
                     cycle_count, exp_q.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int avail;
        int total;
        filter_cond_pkg::packet_t p;
        filter_cond_pkg::cond_cfg_t c;

        void'($urandom(55447));
        areset_generator = 1'b1;
        start            = 1'b0;
        cfg              = '0;
        cfg_valid        = 1'b0;
        in_pkt           = '0;
        in_valid         = 1'b0;
        repeat (8) @(negedge ap_clk);
        areset_generator = 1'b0;
        check_bit("cfg_ready", cfg_ready, 1'b0);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);

        // Packet and count sizes fixed up front so leftovers stay small
        avail = 0;
        total = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            if (j % 7 == 3) begin
                job_new[j] = $urandom % 5;
            end else if (j == BP_JOB) begin
                job_new[j] = 36;
            end else begin
                job_new[j] = 1 + $urandom % 12;
            end
            avail += job_new[j];
            if (j % 7 == 3) begin
                job_count[j] = 0;
            end else if (j == BP_JOB || j == NUM_JOBS - 1 || avail < 3) begin
                job_count[j] = avail;
            end else begin
                job_count[j] = avail - ($urandom % 3);
            end
            avail -= job_count[j];
            total += job_count[j];
        end
        cycle_limit = NUM_JOBS * (total + 64);

        for (int j = 0; j < NUM_JOBS; j++) begin
            for (int i = 0; i < job_new[j]; i++) begin
                p.addr = $urandom;
                p.src  = $urandom;
                p.data = $urandom;
                model_fifo.push_back(p);
                send_q.push_back(p);
            end
            c.op    = filter_cond_pkg::cond_op_t'(j % 6);
            c.mask  = ($urandom % 4 == 0) ? '1 : $urandom;
            c.count = filter_cond_pkg::count_t'(job_count[j]);
            // Operand often taken from this job's data so EQ, LE and GE hit
            if (job_count[j] != 0 && $urandom % 2 == 0) begin
                c.operand = model_fifo[$urandom % job_count[j]].data;
            end else begin
                c.operand = $urandom;
            end
            if (j == BP_JOB) begin
                c.op     = filter_cond_pkg::GE;
                c.mask   = '0;
                bp_phase = 1'b1;
            end
            for (int i = 0; i < job_count[j]; i++) begin
                p = model_fifo.pop_front();
                if (cond_holds(c.op, p.data & c.mask, c.operand & c.mask)) begin
                    exp_q.push_back(p);
                end
            end
            fork
                send_packets();
                run_job(c);
            join
        end

        while (exp_q.size() != 0) @(negedge ap_clk);
        repeat (8) @(negedge ap_clk);
        check_bit("out_valid", out_valid, 1'b0);
        if (done_count != NUM_JOBS) begin
            other_errors++;
            $display("Expected %0d done pulses but saw %0d", NUM_JOBS, done_count);
        end
        if (!saw_in_full) begin
            other_errors++;
            $display("in_ready never fell while the output was stalled");
        end

        $display("Summary: %0d checks, %0d value errors, %0d other errors",
                 n_checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filter_cond_engine.f */
verilog/filter_cond_pkg.sv
verilog/packet_fifo.sv
verilog/filter_cond_control.sv
verilog/filter_cond_kernel.sv
verilog/filter_cond_engine.sv
testbench/filter_cond_engine_tb.sv

/* Bender.yml */
package:
  name: filter_cond_engine

sources:
  - verilog/filter_cond_pkg.sv
  - verilog/packet_fifo.sv
  - verilog/filter_cond_control.sv
  - verilog/filter_cond_kernel.sv
  - verilog/filter_cond_engine.sv
  - target: test
    files:
      - testbench/filter_cond_engine_tb.sv
